//--- rtl/alu_pkg.sv
//----------------------------------------------------------------------
// ALU shared definitions: operation codes, widths, flag positions
//----------------------------------------------------------------------
package alu_pkg;

    localparam int DATA_W  = 32;    // datapath width
    localparam int FLAGS_W = 8;

    // flag bit positions, bits 5 and 3 always read zero
    localparam int FLAG_S = 7;
    localparam int FLAG_Z = 6;
    localparam int FLAG_H = 4;
    localparam int FLAG_V = 2;
    localparam int FLAG_N = 1;
    localparam int FLAG_C = 0;

    // operation select codes
    localparam logic [5:0] ALU_ADD = 6'd1;
    localparam logic [5:0] ALU_ADC = 6'd2;
    localparam logic [5:0] ALU_SUB = 6'd3;
    localparam logic [5:0] ALU_SBC = 6'd4;
    localparam logic [5:0] ALU_CP  = 6'd5;
    localparam logic [5:0] ALU_AND = 6'd6;
    localparam logic [5:0] ALU_OR  = 6'd7;
    localparam logic [5:0] ALU_XOR = 6'd8;
    localparam logic [5:0] ALU_RLC = 6'd9;
    localparam logic [5:0] ALU_RRC = 6'd10;
    localparam logic [5:0] ALU_RL  = 6'd11;
    localparam logic [5:0] ALU_RR  = 6'd12;
    localparam logic [5:0] ALU_SLA = 6'd13;
    localparam logic [5:0] ALU_SRA = 6'd14;
    localparam logic [5:0] ALU_SLL = 6'd15;
    localparam logic [5:0] ALU_SRL = 6'd16;
    localparam logic [5:0] ALU_BIT = 6'd17;
    localparam logic [5:0] ALU_SET = 6'd18;
    localparam logic [5:0] ALU_RES = 6'd19;
    localparam logic [5:0] ALU_CHG = 6'd20;
    localparam logic [5:0] ALU_SCF = 6'd21;
    localparam logic [5:0] ALU_RCF = 6'd22;
    localparam logic [5:0] ALU_CCF = 6'd23;

    typedef enum logic [5:0] {
        OP_ADD = ALU_ADD, OP_ADC = ALU_ADC, OP_SUB = ALU_SUB, OP_SBC = ALU_SBC,
        OP_CP  = ALU_CP,  OP_AND = ALU_AND, OP_OR  = ALU_OR,  OP_XOR = ALU_XOR,
        OP_RLC = ALU_RLC, OP_RRC = ALU_RRC, OP_RL  = ALU_RL,  OP_RR  = ALU_RR,
        OP_SLA = ALU_SLA, OP_SRA = ALU_SRA, OP_SLL = ALU_SLL, OP_SRL = ALU_SRL,
        OP_BIT = ALU_BIT, OP_SET = ALU_SET, OP_RES = ALU_RES, OP_CHG = ALU_CHG,
        OP_SCF = ALU_SCF, OP_RCF = ALU_RCF, OP_CCF = ALU_CCF
    } alu_op_t;

    // one-hot: bit 0 byte, bit 1 word, bit 2 long; all zero means idle
    typedef logic [2:0] alu_width_t;

    typedef enum logic [2:0] {
        CLS_NONE, CLS_ADD, CLS_SUB, CLS_LOGIC, CLS_SHIFT, CLS_BIT, CLS_FLAG
    } alu_class_t;

endpackage

//--- rtl/alu_ctrl_if.sv
//----------------------------------------------------------------------
// ALU decoded control, from decode to execute and result
//----------------------------------------------------------------------
`timescale 1ns/100ps

interface alu_ctrl_if;

    alu_pkg::alu_class_t          op_class;
    alu_pkg::alu_op_t             op;
    alu_pkg::alu_width_t          width;
    logic                         valid;       // width nonzero and known select
    logic [alu_pkg::FLAGS_W-1:0]  flag_we;     // one enable per flag bit
    logic                         keep_dout;   // compare, BIT, flag ops

    modport dec (output op_class, op, width, valid, flag_we, keep_dout);

    // execute needs the width for shift end bits
    modport exe (input op_class, op, width);

    modport res (input valid, width, flag_we, keep_dout, op_class);

endinterface

//--- rtl/alu_raw_if.sv
//----------------------------------------------------------------------
// ALU raw result and carry chain, from execute to result
//----------------------------------------------------------------------
`timescale 1ns/100ps

interface alu_raw_if;

    logic [alu_pkg::DATA_W-1:0] raw;
    logic carry_b;     // out of bit 7
    logic carry_w;     // out of bit 15
    logic carry_l;     // out of bit 31
    logic half;        // H flag value, half carry for add and sub
    logic ovf_b;
    logic ovf_w;
    logic ovf_l;
    logic shift_c;     // new C for shifts and flag ops
    logic bit_z;       // inverted tested bit

    modport exe (output raw, carry_b, carry_w, carry_l, half,
                        ovf_b, ovf_w, ovf_l, shift_c, bit_z);

    modport res (input  raw, carry_b, carry_w, carry_l, half,
                        ovf_b, ovf_w, ovf_l, shift_c, bit_z);

endinterface

//--- rtl/alu_decode.sv
//----------------------------------------------------------------------
// ALU decode: select to operation class and flag write enables
//----------------------------------------------------------------------
`timescale 1ns/100ps

module alu_decode (
    input  alu_pkg::alu_op_t    sel,
    input  alu_pkg::alu_width_t w,
    alu_ctrl_if.dec             ctrl
);

    logic [alu_pkg::FLAGS_W-1:0] s_m, z_m, h_m, v_m, n_m, c_m, all_m;

    assign s_m   = 8'd1 << alu_pkg::FLAG_S;
    assign z_m   = 8'd1 << alu_pkg::FLAG_Z;
    assign h_m   = 8'd1 << alu_pkg::FLAG_H;
    assign v_m   = 8'd1 << alu_pkg::FLAG_V;
    assign n_m   = 8'd1 << alu_pkg::FLAG_N;
    assign c_m   = 8'd1 << alu_pkg::FLAG_C;
    assign all_m = s_m | z_m | h_m | v_m | n_m | c_m;

    always_comb begin
        ctrl.op_class  = alu_pkg::CLS_NONE;
        ctrl.flag_we   = '0;
        ctrl.keep_dout = 1'b0;
        case (sel)
            alu_pkg::OP_ADD, alu_pkg::OP_ADC: begin
                ctrl.op_class = alu_pkg::CLS_ADD;
                ctrl.flag_we  = all_m;
            end
            alu_pkg::OP_SUB, alu_pkg::OP_SBC, alu_pkg::OP_CP: begin
                ctrl.op_class  = alu_pkg::CLS_SUB;
                ctrl.flag_we   = all_m;
                ctrl.keep_dout = (sel == alu_pkg::OP_CP);   // compare only sets flags
            end
            alu_pkg::OP_AND, alu_pkg::OP_OR, alu_pkg::OP_XOR: begin
                ctrl.op_class = alu_pkg::CLS_LOGIC;
                ctrl.flag_we  = all_m;
            end
            alu_pkg::OP_RLC, alu_pkg::OP_RRC, alu_pkg::OP_RL, alu_pkg::OP_RR,
            alu_pkg::OP_SLA, alu_pkg::OP_SRA, alu_pkg::OP_SLL, alu_pkg::OP_SRL: begin
                ctrl.op_class = alu_pkg::CLS_SHIFT;
                ctrl.flag_we  = all_m;
            end
            alu_pkg::OP_BIT: begin
                ctrl.op_class  = alu_pkg::CLS_BIT;
                ctrl.flag_we   = z_m | h_m | n_m;
                ctrl.keep_dout = 1'b1;
            end
            alu_pkg::OP_SET, alu_pkg::OP_RES, alu_pkg::OP_CHG: begin
                ctrl.op_class = alu_pkg::CLS_BIT;   // flags untouched
            end
            alu_pkg::OP_SCF, alu_pkg::OP_RCF: begin
                ctrl.op_class  = alu_pkg::CLS_FLAG;
                ctrl.flag_we   = c_m | n_m | h_m;
                ctrl.keep_dout = 1'b1;
            end
            alu_pkg::OP_CCF: begin
                ctrl.op_class  = alu_pkg::CLS_FLAG;
                ctrl.flag_we   = c_m | n_m;          // H is kept
                ctrl.keep_dout = 1'b1;
            end
            default: ;
        endcase
    end

    assign ctrl.op    = sel;
    assign ctrl.width = w;
    assign ctrl.valid = (w != 3'b000) && (ctrl.op_class != alu_pkg::CLS_NONE);

endmodule

//--- rtl/alu_execute.sv
//----------------------------------------------------------------------
// ALU datapath: split adder, logic unit, shifter and bit operations
//----------------------------------------------------------------------
`timescale 1ns/100ps

module alu_execute (
    input  logic [alu_pkg::DATA_W-1:0] op0,
    input  logic [alu_pkg::DATA_W-1:0] op1,
    input  logic                       carry,
    alu_ctrl_if.exe                    ctrl,
    alu_raw_if.exe                     raw
);

    logic                       sub, cin, c0, h, cb, cw, cl;
    logic                       sgn, lin, rin, left;
    logic [alu_pkg::DATA_W-1:0] b, sum, logic_r, shl, shr, bit_m, bit_r;
    logic [8:0]                 ext_b;
    logic [16:0]                ext_w;
    logic [32:0]                ext_l;

    // subtract runs as a + ~b + ~cin, so carries come out as not-borrow
    assign sub = (ctrl.op_class == alu_pkg::CLS_SUB);
    assign cin = carry && (ctrl.op == alu_pkg::OP_ADC || ctrl.op == alu_pkg::OP_SBC);
    assign b   = sub ? ~op1 : op1;
    assign c0  = cin ^ sub;

    assign {h,  sum[3:0]}   = {1'b0, op0[3:0]}   + {1'b0, b[3:0]}   + {4'd0, c0};
    assign {cb, sum[7:4]}   = {1'b0, op0[7:4]}   + {1'b0, b[7:4]}   + {4'd0, h};
    assign {cw, sum[15:8]}  = {1'b0, op0[15:8]}  + {1'b0, b[15:8]}  + {8'd0, cb};
    assign {cl, sum[31:16]} = {1'b0, op0[31:16]} + {1'b0, b[31:16]} + {16'd0, cw};

    // overflow from sign-extended operands at each width
    assign ext_b = {op0[7], op0[7:0]}   + {b[7], b[7:0]}   + {8'd0, c0};
    assign ext_w = {op0[15], op0[15:0]} + {b[15], b[15:0]} + {16'd0, c0};
    assign ext_l = {op0[31], op0}       + {b[31], b}       + {32'd0, c0};

    assign raw.carry_b = cb ^ sub;
    assign raw.carry_w = cw ^ sub;
    assign raw.carry_l = cl ^ sub;
    assign raw.ovf_b   = ext_b[8] ^ ext_b[7];
    assign raw.ovf_w   = ext_w[16] ^ ext_w[15];
    assign raw.ovf_l   = ext_l[32] ^ ext_l[31];

    assign logic_r = (ctrl.op == alu_pkg::OP_AND) ? (op0 & op1) :
                     (ctrl.op == alu_pkg::OP_OR)  ? (op0 | op1) : (op0 ^ op1);

    // one-position shifts, end bits follow the width
    assign sgn  = ctrl.width[0] ? op0[7] : ctrl.width[1] ? op0[15] : op0[31];
    assign left = ctrl.op inside {alu_pkg::OP_RLC, alu_pkg::OP_RL,
                                  alu_pkg::OP_SLA, alu_pkg::OP_SLL};
    assign lin  = (ctrl.op == alu_pkg::OP_RLC) ? sgn :
                  (ctrl.op == alu_pkg::OP_RL)  ? carry : 1'b0;
    assign rin  = (ctrl.op == alu_pkg::OP_RRC) ? op0[0] :
                  (ctrl.op == alu_pkg::OP_RR)  ? carry  :
                  (ctrl.op == alu_pkg::OP_SRA) ? sgn    : 1'b0;
    assign shl  = {op0[30:0], lin};

    always_comb begin
        shr = {1'b0, op0[31:1]};
        if (ctrl.width[0]) begin
            shr[7] = rin;
        end else if (ctrl.width[1]) begin
            shr[15] = rin;
        end else begin
            shr[31] = rin;
        end
    end

    assign bit_m     = 32'd1 << op1[3:0];
    assign bit_r     = (ctrl.op == alu_pkg::OP_SET) ? (op0 | bit_m) :
                       (ctrl.op == alu_pkg::OP_RES) ? (op0 & ~bit_m) : (op0 ^ bit_m);
    assign raw.bit_z = ~op0[op1[3:0]];

    always_comb begin
        raw.raw     = sum;
        raw.half    = h ^ sub;
        raw.shift_c = left ? sgn : op0[0];   // bit that leaves
        case (ctrl.op_class)
            alu_pkg::CLS_LOGIC: begin
                raw.raw  = logic_r;
                raw.half = (ctrl.op == alu_pkg::OP_AND);
            end
            alu_pkg::CLS_SHIFT: begin
                raw.raw  = left ? shl : shr;
                raw.half = 1'b0;
            end
            alu_pkg::CLS_BIT: begin
                raw.raw  = bit_r;
                raw.half = 1'b1;
            end
            alu_pkg::CLS_FLAG: begin
                raw.half    = 1'b0;
                raw.shift_c = (ctrl.op == alu_pkg::OP_SCF) ? 1'b1 :
                              (ctrl.op == alu_pkg::OP_RCF) ? 1'b0 : ~carry;
            end
            default: ;
        endcase
    end

endmodule

//--- rtl/alu_result.sv
//----------------------------------------------------------------------
// ALU result stage: flags by width, result and flag registers
//----------------------------------------------------------------------
`timescale 1ns/100ps

module alu_result (
    input  logic                        clk,
    input  logic                        rst,
    input  alu_pkg::alu_width_t         w,
    alu_ctrl_if.res                     ctrl,
    alu_raw_if.res                      raw,
    output logic                        carry,
    output logic [alu_pkg::DATA_W-1:0]  dout,
    output logic [alu_pkg::FLAGS_W-1:0] flags,
    output logic [2:0]                  alu_we
);

    logic [alu_pkg::DATA_W-1:0]  mask, rslt;
    logic [alu_pkg::FLAGS_W-1:0] nx;
    logic                        sign, zero, even, cy, ov, arith;

    assign mask = ctrl.width[0] ? 32'h0000_00ff :
                  ctrl.width[1] ? 32'h0000_ffff : 32'hffff_ffff;
    assign rslt = raw.raw & mask;    // zero-extended from the width

    assign sign  = ctrl.width[0] ? rslt[7] : ctrl.width[1] ? rslt[15] : rslt[31];
    assign zero  = (rslt == '0);
    assign even  = ctrl.width[0] ? ~^rslt[7:0] : ~^rslt[15:0];
    assign cy    = ctrl.width[0] ? raw.carry_b : ctrl.width[1] ? raw.carry_w : raw.carry_l;
    assign ov    = ctrl.width[0] ? raw.ovf_b : ctrl.width[1] ? raw.ovf_w : raw.ovf_l;
    assign arith = (ctrl.op_class == alu_pkg::CLS_ADD) || (ctrl.op_class == alu_pkg::CLS_SUB);

    always_comb begin
        nx = '0;
        nx[alu_pkg::FLAG_S] = sign;
        nx[alu_pkg::FLAG_Z] = (ctrl.op_class == alu_pkg::CLS_BIT) ? raw.bit_z : zero;
        nx[alu_pkg::FLAG_H] = raw.half;
        nx[alu_pkg::FLAG_V] = arith ? ov : even;   // parity otherwise
        nx[alu_pkg::FLAG_N] = (ctrl.op_class == alu_pkg::CLS_SUB);
        if (arith) begin
            nx[alu_pkg::FLAG_C] = cy;
        end else if (ctrl.op_class == alu_pkg::CLS_LOGIC) begin
            nx[alu_pkg::FLAG_C] = 1'b0;
        end else begin
            nx[alu_pkg::FLAG_C] = raw.shift_c;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dout   <= '0;
            flags  <= '0;
            alu_we <= 3'b000;
        end else begin
            alu_we <= ctrl.valid ? w : 3'b000;
            if (ctrl.valid) begin
                flags <= (flags & ~ctrl.flag_we) | (nx & ctrl.flag_we);
                if (!ctrl.keep_dout) begin
                    dout <= rslt;
                end
            end
        end
    end

    assign carry = flags[alu_pkg::FLAG_C];   // fed back for ADC, SBC, RL, RR, CCF

endmodule

//--- rtl/alu_top.sv
//----------------------------------------------------------------------
// ALU top level: decode, execute and result stages
//----------------------------------------------------------------------
`timescale 1ns/100ps

module alu_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [alu_pkg::DATA_W-1:0]  op0,
    input  logic [alu_pkg::DATA_W-1:0]  op1,
    input  logic [5:0]                  sel,
    input  logic [2:0]                  w,
    output logic [alu_pkg::DATA_W-1:0]  dout,
    output logic [alu_pkg::FLAGS_W-1:0] flags,
    output logic [2:0]                  alu_we
);

    logic carry;   // current C flag

    alu_ctrl_if ctrl_if ();
    alu_raw_if  raw_if ();

    alu_decode u_decode (
        .sel  (alu_pkg::alu_op_t'(sel)),
        .w    (w),
        .ctrl (ctrl_if.dec)
    );

    alu_execute u_execute (
        .op0   (op0),
        .op1   (op1),
        .carry (carry),
        .ctrl  (ctrl_if.exe),
        .raw   (raw_if.exe)
    );

    alu_result u_result (
        .clk    (clk),
        .rst    (rst),
        .w      (w),
        .ctrl   (ctrl_if.res),
        .raw    (raw_if.res),
        .carry  (carry),
        .dout   (dout),
        .flags  (flags),
        .alu_we (alu_we)
    );

endmodule

//--- include/alu_ref_model.svh
//----------------------------------------------------------------------
// ALU reference model: expected result and flags of one operation
//----------------------------------------------------------------------
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// returns {dout, flags} after one operation, fl is the flag state before
function automatic logic [39:0] alu_ref(
    input logic [5:0]  sel,
    input logic [2:0]  w,
    input logic [31:0] a,
    input logic [31:0] b,
    input logic [31:0] dout,
    input logic [7:0]  fl
);
    int unsigned n;
    logic [63:0] m, full;
    logic [31:0] r;
    logic [7:0]  we, nf;
    logic [4:0]  hs;
    logic        fc, cin, sub, sa, sb, lin, rin, h, v, nn, c, keep;
    n    = w[0] ? 8 : w[1] ? 16 : 32;
    m    = (64'd1 << n) - 64'd1;
    fc   = fl[alu_pkg::FLAG_C];
    cin  = fc && (sel == alu_pkg::ALU_ADC || sel == alu_pkg::ALU_SBC);
    sub  = (sel == alu_pkg::ALU_SUB || sel == alu_pkg::ALU_SBC || sel == alu_pkg::ALU_CP);
    sa   = a[n-1];
    sb   = b[n-1];
    r    = dout;
    {h, v, nn, c, keep} = 5'b00000;
    we   = 8'hd7;     // S Z H V N C
    if (w == 3'b000) begin
        return {dout, fl};
    end
    case (sel)
        alu_pkg::ALU_ADD, alu_pkg::ALU_ADC, alu_pkg::ALU_SUB, alu_pkg::ALU_SBC,
        alu_pkg::ALU_CP: begin
            full = sub ? (a & m) - (b & m) - cin : (a & m) + (b & m) + cin;
            hs   = sub ? {1'b0, a[3:0]} - {1'b0, b[3:0]} - cin :
                         {1'b0, a[3:0]} + {1'b0, b[3:0]} + cin;
            r    = full[31:0] & m[31:0];
            h    = hs[4];
            c    = full[n];
            nn   = sub;
            v    = ((sb ^ sub) == sa) && (r[n-1] != sa);
            keep = (sel == alu_pkg::ALU_CP);
        end
        alu_pkg::ALU_AND, alu_pkg::ALU_OR, alu_pkg::ALU_XOR: begin
            r = (sel == alu_pkg::ALU_AND) ? a & b : (sel == alu_pkg::ALU_OR) ? a | b : a ^ b;
            r = r & m[31:0];
            h = (sel == alu_pkg::ALU_AND);
        end
        alu_pkg::ALU_RLC, alu_pkg::ALU_RL, alu_pkg::ALU_SLA, alu_pkg::ALU_SLL: begin
            lin = (sel == alu_pkg::ALU_RLC) ? sa : (sel == alu_pkg::ALU_RL) ? fc : 1'b0;
            r   = ((a << 1) | 32'(lin)) & m[31:0];
            c   = sa;
        end
        alu_pkg::ALU_RRC, alu_pkg::ALU_RR, alu_pkg::ALU_SRA, alu_pkg::ALU_SRL: begin
            rin = (sel == alu_pkg::ALU_RRC) ? a[0] : (sel == alu_pkg::ALU_RR) ? fc :
                  (sel == alu_pkg::ALU_SRA) ? sa : 1'b0;
            r   = ((a & m[31:0]) >> 1) | (32'(rin) << (n - 1));
            c   = a[0];
        end
        alu_pkg::ALU_BIT: begin
            h    = 1'b1;
            we   = 8'h52;     // Z H N
            keep = 1'b1;
        end
        alu_pkg::ALU_SET: r = (a | (32'd1 << b[3:0])) & m[31:0];
        alu_pkg::ALU_RES: r = (a & ~(32'd1 << b[3:0])) & m[31:0];
        alu_pkg::ALU_CHG: r = (a ^ (32'd1 << b[3:0])) & m[31:0];
        alu_pkg::ALU_SCF, alu_pkg::ALU_RCF, alu_pkg::ALU_CCF: begin
            c    = (sel == alu_pkg::ALU_SCF) ? 1'b1 : (sel == alu_pkg::ALU_RCF) ? 1'b0 : ~fc;
            we   = (sel == alu_pkg::ALU_CCF) ? 8'h03 : 8'h13;
            keep = 1'b1;
        end
        default: return {dout, fl};
    endcase
    if (sel inside {alu_pkg::ALU_SET, alu_pkg::ALU_RES, alu_pkg::ALU_CHG}) begin
        we = 8'h00;
    end
    if (!sub && sel inside {[alu_pkg::ALU_AND:alu_pkg::ALU_SRL]}) begin
        v = w[0] ? ~^r[7:0] : ~^r[15:0];   // even parity
    end
    nf = {r[n-1], (sel == alu_pkg::ALU_BIT) ? ~a[b[3:0]] : (r == 32'd0),
          1'b0, h, 1'b0, v, nn, c};
    nf = (fl & ~we) | (nf & we);
    return {keep ? dout : r, nf};
endfunction

`endif

//--- tests/alu_tb.sv
//----------------------------------------------------------------------
// ALU testbench: random operations checked against a reference model
//----------------------------------------------------------------------
`timescale 1ns/100ps

module alu_tb;

    `include "alu_ref_model.svh"

    localparam int          CLK_HALF    = 20;     // 40 ns period
    localparam int          RST_CYCLES  = 10;
    localparam int          RST_TIMEOUT = 50;
    localparam int          IDLE_LIMIT  = 8;
    localparam logic [31:0] SEED        = 32'h2035;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic [31:0] op0 = '0;
    logic [31:0] op1 = '0;
    logic [5:0]  sel = '0;
    logic [2:0]  w   = '0;
    logic [31:0] dout;
    logic [7:0]  flags;
    logic [2:0]  alu_we;

    // expected state after the last driven operation
    logic [31:0] exp_dout  = '0;
    logic [7:0]  exp_flags = '0;
    logic [2:0]  exp_we    = '0;

    int err_cnt  = 0;
    int err_mark = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;

    alu_top alu_top_i (
        .clk    (clk),
        .rst    (rst),
        .op0    (op0),
        .op1    (op1),
        .sel    (sel),
        .w      (w),
        .dout   (dout),
        .flags  (flags),
        .alu_we (alu_we)
    );

    initial begin
        forever #CLK_HALF clk = ~clk;
    end

    initial begin
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

    // outputs at the falling edge hold the op driven one cycle before
    assert property (@(negedge clk) disable iff (rst) dout == exp_dout)
        else report_mismatch("dout", $sampled(exp_dout), $sampled(dout));
    assert property (@(negedge clk) disable iff (rst) flags == exp_flags)
        else report_mismatch("flags", 32'($sampled(exp_flags)), 32'($sampled(flags)));
    assert property (@(negedge clk) disable iff (rst) alu_we == exp_we)
        else report_mismatch("alu_we", 32'($sampled(exp_we)), 32'($sampled(alu_we)));

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        err_cnt = err_cnt + 1;
        $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
    endtask

    task automatic abort(input string reason);
        $display("timeout: %s", reason);
        $display("Regression failed");
        $finish;
    endtask

    // drive one op at the falling edge and advance the expected state
    task automatic apply_op(input logic [5:0] s, input logic [2:0] wd,
                            input logic [31:0] a, input logic [31:0] b);
        logic [39:0] nxt;
        @(negedge clk);
        sel = s;
        w   = wd;
        op0 = a;
        op1 = b;
        nxt       = alu_ref(s, wd, a, b, exp_dout, exp_flags);
        exp_dout  = nxt[39:8];
        exp_flags = nxt[7:0];
        exp_we    = (wd != 3'b000 && s >= alu_pkg::ALU_ADD && s <= alu_pkg::ALU_CCF) ?
                    wd : 3'b000;
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (rst && n < RST_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (rst) begin
            abort("reset was never released");
        end
    endtask

    // idle until the strobe drops, so every pending check has fired
    task automatic wait_idle();
        int n;
        n = 0;
        apply_op(6'd0, 3'b000, '0, '0);
        while (alu_we != 3'b000 && n < IDLE_LIMIT) begin
            apply_op(6'd0, 3'b000, '0, '0);
            n++;
        end
        if (alu_we != 3'b000) begin
            abort("write strobe stayed high with idle inputs");
        end
        @(posedge clk);   // checks of the last falling edge report first
    endtask

    task automatic end_test(input string name);
        wait_idle();
        if (err_cnt == err_mark) begin
            pass_cnt++;
            $display("test %-10s done, no errors", name);
        end else begin
            fail_cnt++;
            $display("test %-10s done, %0d errors", name, err_cnt - err_mark);
        end
        err_mark = err_cnt;
    endtask

    function automatic logic [2:0] rand_width();
        case ($urandom % 3)
            0:       return 3'b001;
            1:       return 3'b010;
            default: return 3'b100;
        endcase
    endfunction

    // random word, often an edge value to reach carries and overflow
    function automatic logic [31:0] pick_operand();
        logic [31:0] r;
        r = $urandom;
        case ($urandom % 8)
            0: r = 32'h0000_0000;
            1: r = 32'hffff_ffff;
            2: r = 32'h0000_007f;
            3: r = 32'h0000_8000;
            4: r = 32'h7fff_ffff;
            default: ;
        endcase
        return r;
    endfunction

    initial begin
        int i;
        void'($urandom(SEED));
        wait_reset_release();

        // sets H, V and C so that kept flags are not all zero
        apply_op(alu_pkg::ALU_ADD, 3'b100, 32'h8765_4321, 32'h8000_0fff);
        for (i = 0; i < 20; i++) begin
            apply_op(6'($urandom), 3'b000, $urandom, $urandom);   // zero width
        end
        for (i = 0; i < 20; i++) begin
            apply_op((i == 0) ? 6'd0 : 6'(24 + $urandom % 40), rand_width(),
                     $urandom, $urandom);
        end
        end_test("reset_idle");

        for (i = 0; i < 300; i++) begin
            apply_op(6'(alu_pkg::ALU_ADD + $urandom % 5), rand_width(),
                     pick_operand(), pick_operand());
        end
        end_test("arith");

        for (i = 0; i < 150; i++) begin
            apply_op(6'(alu_pkg::ALU_AND + $urandom % 3), rand_width(),
                     pick_operand(), pick_operand());
        end
        end_test("logic");

        for (i = 0; i < 300; i++) begin
            apply_op(6'(alu_pkg::ALU_RLC + $urandom % 8), rand_width(),
                     pick_operand(), $urandom);
        end
        end_test("shift");

        for (i = 0; i < 300; i++) begin
            apply_op(6'(alu_pkg::ALU_BIT + $urandom % 7), rand_width(),
                     pick_operand(), $urandom);
        end
        end_test("bit_flag");

        // carry chain through consecutive cycles
        apply_op(alu_pkg::ALU_SCF, 3'b001, '0, '0);
        for (i = 0; i < 100; i++) begin
            apply_op(($urandom % 4 == 0) ? alu_pkg::ALU_SBC : alu_pkg::ALU_ADC,
                     rand_width(), pick_operand(), pick_operand());
        end
        end_test("carry_chain");

        $display("tests passed: %0d, tests failed: %0d, check errors: %0d",
                 pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+include
rtl/alu_pkg.sv
rtl/alu_ctrl_if.sv
rtl/alu_raw_if.sv
rtl/alu_decode.sv
rtl/alu_execute.sv
rtl/alu_result.sv
rtl/alu_top.sv
tests/alu_tb.sv
